// File: rtl/tm_disp_pkg.sv
/*
 * shared types for the serial seven-segment display controller
 * digit, segment and bus byte widths, the sequencer to bus master
 * structs, the sequencer states and the display command bytes
 */

`default_nettype none

package tm_disp_pkg;

	// ------------------------------
	// plain widths
	// ------------------------------
	typedef logic [3:0] digit_t;
	// bit 0 = a ... bit 6 = g, active high
	typedef logic [6:0] seg_t;
	typedef logic [7:0] bus_byte_t;
	typedef logic [2:0] brightness_t;

	// ------------------------------
	// sequencer <-> bus master
	// ------------------------------
	typedef struct packed {
		logic      enable;
		bus_byte_t data;
	} bus_req_t;

	typedef struct packed {
		// idle, line stopped
		logic ready;
		// one cycle, after each ack clock
		logic next_word;
	} bus_stat_t;

	typedef enum logic [3:0] {
		WaitPeriod,
		WaitUpdate,
		SendMode,
		EndMode,
		SendAddr,
		SendDigit,
		EndData,
		SendCtrl,
		EndCtrl
	} seq_state_t;

	// ------------------------------
	// command bytes
	// ------------------------------
	// data write, constant address
	localparam bus_byte_t CMD_DATA_MODE = 8'h44;
	// first digit address
	localparam bus_byte_t CMD_ADDR0     = 8'hC0;
	// display on, brightness goes in bits 2:0
	localparam bus_byte_t CMD_DISP_ON   = 8'h88;

endpackage

`default_nettype wire

// File: rtl/seg_decoder.sv
/*
 * hex digit to seven-segment decoder
 * purely combinational, segments active high
 */

`timescale 1ns/1ns
`default_nettype none

module seg_decoder
	import tm_disp_pkg::*;
(
	input  digit_t in_digit,
	output seg_t   out_segs
);

	// ------------------------------
	// pattern table, gfedcba
	// ------------------------------
	always_comb begin
		unique case (in_digit)
			4'h0: out_segs = 7'h3F;
			4'h1: out_segs = 7'h06;
			4'h2: out_segs = 7'h5B;
			4'h3: out_segs = 7'h4F;
			4'h4: out_segs = 7'h66;
			4'h5: out_segs = 7'h6D;
			4'h6: out_segs = 7'h7D;
			4'h7: out_segs = 7'h07;
			4'h8: out_segs = 7'h7F;
			4'h9: out_segs = 7'h6F;
			// letters, lower case b and d
			4'hA: out_segs = 7'h77;
			4'hB: out_segs = 7'h7C;
			4'hC: out_segs = 7'h39;
			4'hD: out_segs = 7'h5E;
			4'hE: out_segs = 7'h79;
			4'hF: out_segs = 7'h71;
			// unreachable for a 4 bit digit
			default: out_segs = 7'h00;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/wait_timer.sv
/*
 * refresh period timer
 * counts WAIT_CYCLES after a start pulse or reset, then holds done high
 */

`timescale 1ns/1ns
`default_nettype none

module wait_timer #(
	parameter int WAIT_CYCLES = 5_000_000
) (
	input  logic in_clk,
	input  logic in_rst,
	input  logic in_start,
	output logic out_done
);

	localparam int CTR_W = $clog2(WAIT_CYCLES + 1);

	logic [CTR_W-1:0] wait_ctr;

	// reset acts like a start
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			wait_ctr <= '0;
		end else if (in_start) begin
			wait_ctr <= '0;
		end else if (!out_done) begin
			wait_ctr <= wait_ctr + 1'b1;
		end
	end

	// level, held until the next start
	assign out_done = (wait_ctr == CTR_W'(WAIT_CYCLES));

endmodule

`default_nettype wire

// File: rtl/disp_sequencer.sv
/*
 * display frame sequencer
 * holds the digit store and update flag, then walks one frame:
 * mode command, address plus segment bytes, control command
 */

`timescale 1ns/1ns
`default_nettype none

module disp_sequencer
	import tm_disp_pkg::*;
#(
	parameter int NUM_DIGITS = 6
) (
	input  logic                         in_clk,
	input  logic                         in_rst,
	input  logic                         in_update,
	input  digit_t [NUM_DIGITS-1:0]      in_digits,
	input  brightness_t                  in_brightness,
	input  logic                         in_timer_done,
	output logic                         out_timer_start,
	output digit_t                       out_digit,
	input  seg_t                         in_segs,
	output bus_req_t                     out_req,
	input  bus_stat_t                    in_stat
);

	localparam int CTR_W = (NUM_DIGITS > 1) ? $clog2(NUM_DIGITS) : 1;

	seq_state_t state, next_state;

	digit_t [NUM_DIGITS-1:0] digit_mem;
	brightness_t             bright_mem;
	logic                    update_flag;
	logic [CTR_W-1:0]        digit_ctr;

	// ------------------------------
	// digit store
	// ------------------------------
	// digits and brightness latched together
	always_ff @(posedge in_clk) begin
		if (in_update) begin
			digit_mem  <= in_digits;
			bright_mem <= in_brightness;
		end
	end

	// ------------------------------
	// control registers
	// ------------------------------
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state       <= WaitPeriod;
			update_flag <= 1'b0;
			digit_ctr   <= '0;
		end else begin
			state <= next_state;
			// set beats the clear at frame start
			if (in_update) begin
				update_flag <= 1'b1;
			end else if (state == WaitUpdate && update_flag) begin
				update_flag <= 1'b0;
			end
			// digit index steps on each finished segment byte
			if (state == SendAddr) begin
				digit_ctr <= '0;
			end else if (state == SendDigit && in_stat.next_word) begin
				digit_ctr <= digit_ctr + 1'b1;
			end
		end
	end

	// ------------------------------
	// next state
	// ------------------------------
	always_comb begin
		next_state = state;
		unique case (state)
			WaitPeriod: if (in_timer_done) next_state = WaitUpdate;
			WaitUpdate: if (update_flag) next_state = SendMode;
			// single byte part, enable drops after its ack
			SendMode:   if (in_stat.next_word) next_state = EndMode;
			EndMode:    if (in_stat.ready) next_state = SendAddr;
			// address chains straight into the digits
			SendAddr:   if (in_stat.next_word) next_state = SendDigit;
			SendDigit: begin
				if (in_stat.next_word && digit_ctr == CTR_W'(NUM_DIGITS - 1)) begin
					next_state = EndData;
				end
			end
			EndData:    if (in_stat.ready) next_state = SendCtrl;
			SendCtrl:   if (in_stat.next_word) next_state = EndCtrl;
			EndCtrl:    if (in_stat.ready) next_state = WaitPeriod;
			default:    next_state = WaitPeriod;
		endcase
	end

	// ------------------------------
	// outputs
	// ------------------------------
	always_comb begin
		out_req.enable = 1'b0;
		out_req.data   = '0;
		unique case (state)
			SendMode: begin
				out_req.enable = 1'b1;
				out_req.data   = CMD_DATA_MODE;
			end
			SendAddr: begin
				out_req.enable = 1'b1;
				out_req.data   = CMD_ADDR0;
			end
			SendDigit: begin
				out_req.enable = 1'b1;
				// top bit is the unused dot
				out_req.data   = {1'b0, in_segs};
			end
			SendCtrl: begin
				out_req.enable = 1'b1;
				out_req.data   = CMD_DISP_ON | {5'b0, bright_mem};
			end
			default: begin
				out_req.enable = 1'b0;
			end
		endcase
	end

	assign out_digit = digit_mem[digit_ctr];

	// next period starts once the last stop is out
	assign out_timer_start = (state == EndCtrl) && in_stat.ready;

endmodule

`default_nettype wire

// File: rtl/tm_bus_master.sv
/*
 * two-wire display bus master
 * start, eight data bits lsb first, ack clock, gap half-bit,
 * then either the next chained byte or a stop
 */

`timescale 1ns/1ns
`default_nettype none

module tm_bus_master
	import tm_disp_pkg::*;
#(
	parameter int HALF_BIT = 250
) (
	input  logic      in_clk,
	input  logic      in_rst,
	input  bus_req_t  in_req,
	output bus_stat_t out_stat,
	output logic      out_disp_clk,
	output logic      out_disp_dio
);

	localparam int HB_W = (HALF_BIT > 1) ? $clog2(HALF_BIT) : 1;

	typedef enum logic [2:0] {
		PhIdle,
		PhStart,
		PhBits,
		PhAck,
		PhGap,
		PhStop
	} phase_t;

	phase_t          phase;
	logic [HB_W-1:0] hb_ctr;
	logic            half_q;
	logic [2:0]      bit_ctr;
	bus_byte_t       shift_q;
	logic            next_word_q;
	logic            tick;

	// end of the current half-bit
	assign tick = (hb_ctr == HB_W'(HALF_BIT - 1));

	// ------------------------------
	// phase, divider and bit count
	// ------------------------------
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			phase       <= PhIdle;
			hb_ctr      <= '0;
			half_q      <= 1'b0;
			bit_ctr     <= '0;
			next_word_q <= 1'b0;
		end else begin
			next_word_q <= 1'b0;
			if (phase == PhIdle) begin
				hb_ctr <= '0;
				if (in_req.enable) phase <= PhStart;
			end else begin
				hb_ctr <= tick ? '0 : hb_ctr + 1'b1;
				if (tick) begin
					unique case (phase)
						PhStart: begin
							phase   <= PhBits;
							half_q  <= 1'b0;
							bit_ctr <= '0;
						end
						PhBits: begin
							half_q <= ~half_q;
							if (half_q) begin
								bit_ctr <= bit_ctr + 1'b1;
								if (bit_ctr == 3'd7) phase <= PhAck;
							end
						end
						PhAck: begin
							half_q <= ~half_q;
							if (half_q) begin
								phase       <= PhGap;
								next_word_q <= 1'b1;
							end
						end
						// chain or stop
						PhGap: begin
							if (in_req.enable) begin
								phase   <= PhBits;
								half_q  <= 1'b0;
								bit_ctr <= '0;
							end else begin
								phase <= PhStop;
							end
						end
						default: phase <= PhIdle;
					endcase
				end
			end
		end
	end

	// shifter, loaded at idle start or gap chain
	always_ff @(posedge in_clk) begin
		if ((phase == PhIdle && in_req.enable) || (phase == PhGap && tick && in_req.enable)) begin
			shift_q <= in_req.data;
		end else if (phase == PhBits && tick && half_q) begin
			shift_q <= shift_q >> 1;
		end
	end

	// ------------------------------
	// line levels
	// ------------------------------
	always_comb begin
		unique case (phase)
			PhIdle:  {out_disp_clk, out_disp_dio} = 2'b11;
			// dio falls with clk high
			PhStart: {out_disp_clk, out_disp_dio} = 2'b10;
			PhBits:  {out_disp_clk, out_disp_dio} = {half_q, shift_q[0]};
			// dio released during ack
			PhAck:   {out_disp_clk, out_disp_dio} = {half_q, 1'b1};
			PhGap:   {out_disp_clk, out_disp_dio} = 2'b00;
			// clk up with dio low, dio rises on idle
			PhStop:  {out_disp_clk, out_disp_dio} = 2'b10;
			default: {out_disp_clk, out_disp_dio} = 2'b11;
		endcase
	end

	assign out_stat.ready     = (phase == PhIdle);
	assign out_stat.next_word = next_word_q;

endmodule

`default_nettype wire

// File: rtl/tm_display_top.sv
/*
 * serial seven-segment display controller, top level
 * sequencer, refresh timer, segment decoder and bus master
 */

`timescale 1ns/1ns
`default_nettype none

module tm_display_top
	import tm_disp_pkg::*;
#(
	parameter int NUM_DIGITS  = 6,
	// 100 ms at 50 MHz
	parameter int WAIT_CYCLES = 5_000_000,
	// 100 kHz bit rate at 50 MHz
	parameter int HALF_BIT    = 250
) (
	input  logic                    in_clk,
	input  logic                    in_rst,
	input  logic                    in_update,
	input  digit_t [NUM_DIGITS-1:0] in_digits,
	input  brightness_t             in_brightness,
	output logic                    out_disp_clk,
	output logic                    out_disp_dio
);

	logic      timer_start;
	logic      timer_done;
	digit_t    cur_digit;
	seg_t      cur_segs;
	bus_req_t  bus_req;
	bus_stat_t bus_stat;

	// ------------------------------
	// frame control
	// ------------------------------
	disp_sequencer #(
		.NUM_DIGITS(NUM_DIGITS)
	) seq0 (
		.in_clk         (in_clk),
		.in_rst         (in_rst),
		.in_update      (in_update),
		.in_digits      (in_digits),
		.in_brightness  (in_brightness),
		.in_timer_done  (timer_done),
		.out_timer_start(timer_start),
		.out_digit      (cur_digit),
		.in_segs        (cur_segs),
		.out_req        (bus_req),
		.in_stat        (bus_stat)
	);

	wait_timer #(
		.WAIT_CYCLES(WAIT_CYCLES)
	) timer0 (
		.in_clk  (in_clk),
		.in_rst  (in_rst),
		.in_start(timer_start),
		.out_done(timer_done)
	);

	seg_decoder dec0 (
		.in_digit(cur_digit),
		.out_segs(cur_segs)
	);

	// ------------------------------
	// line side
	// ------------------------------
	tm_bus_master #(
		.HALF_BIT(HALF_BIT)
	) bus0 (
		.in_clk      (in_clk),
		.in_rst      (in_rst),
		.in_req      (bus_req),
		.out_stat    (bus_stat),
		.out_disp_clk(out_disp_clk),
		.out_disp_dio(out_disp_dio)
	);

endmodule

`default_nettype wire

// File: tests/tm_display_chk.sv
/*
 * bound protocol checks for the display controller
 * word pulse width, idle line clock, enable handshake, state range
 */

`timescale 1ns/1ns
`default_nettype none

module tm_display_chk
	import tm_disp_pkg::*;
(
	input logic       in_clk,
	input logic       in_rst,
	input bus_req_t   req,
	input bus_stat_t  stat,
	input logic       line_clk,
	input seq_state_t state
);

	// ------------------------------
	// handshake
	// ------------------------------
	a_next_word_single: assert property (@(posedge in_clk) disable iff (in_rst)
		stat.next_word |=> !stat.next_word)
		else $error("next_word high two cycles in a row");

	// a new part only starts on an idle master
	a_enable_on_ready: assert property (@(posedge in_clk) disable iff (in_rst)
		$rose(req.enable) |-> stat.ready)
		else $error("enable rose while the bus master was busy");

	// idle line keeps its clock high
	a_idle_clk_high: assert property (@(posedge in_clk) disable iff (in_rst)
		stat.ready |-> line_clk)
		else $error("line clock low while the bus master is ready");

	a_state_legal: assert property (@(posedge in_clk) disable iff (in_rst)
		state inside {WaitPeriod, WaitUpdate, SendMode, EndMode, SendAddr,
			SendDigit, EndData, SendCtrl, EndCtrl})
		else $error("sequencer state outside its enum");

endmodule

// sequencer to bus master link, line clock and sequencer state together
bind tm_display_top tm_display_chk chk0 (
	.in_clk(in_clk), .in_rst(in_rst), .req(bus_req), .stat(bus_stat),
	.line_clk(out_disp_clk), .state(seq0.state)
);

`default_nettype wire

// File: tests/tm_display_tb.sv
/*
 * testbench for the serial seven-segment display controller
 * decodes the two-wire line into bytes per frame part
 * and checks each frame against its own command and segment tables
 */

`timescale 1ns/1ns
`default_nettype none

module tm_display_tb
	import tm_disp_pkg::*;
();

	localparam int NUM_DIGITS  = 6;
	localparam int WAIT_CYCLES = 200;
	localparam int HALF_BIT    = 4;
	localparam int CLK_PERIOD  = 40;
	localparam int DRIVE_DELAY = 5;
	// one frame plus its refresh wait
	localparam int FRAME_CYCLES   = (3 + 2 + 6) * 19 * HALF_BIT + WAIT_CYCLES;
	// 7 frames and 9 idle wait periods, with headroom
	localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES + 1000;

	typedef digit_t [NUM_DIGITS-1:0] digit_vec_t;

	logic        in_clk;
	logic        in_rst;
	logic        in_update;
	digit_vec_t  in_digits;
	brightness_t in_brightness;
	logic        out_disp_clk;
	logic        out_disp_dio;

	// line model
	logic      prev_clk  = 1'b1;
	logic      prev_dio  = 1'b1;
	int        bit_idx   = 0;
	bus_byte_t rx_byte   = '0;
	int        start_cnt = 0;
	int        stop_cnt  = 0;
	bus_byte_t byte_q[$];
	int        part_q[$];

	int          next_part = 0;
	int          cycle_ctr = 0;
	logic [31:0] lfsr_state;

	tm_display_top #(
		.NUM_DIGITS (NUM_DIGITS),
		.WAIT_CYCLES(WAIT_CYCLES),
		.HALF_BIT   (HALF_BIT)
	) dut0 (
		.in_clk       (in_clk),
		.in_rst       (in_rst),
		.in_update    (in_update),
		.in_digits    (in_digits),
		.in_brightness(in_brightness),
		.out_disp_clk (out_disp_clk),
		.out_disp_dio (out_disp_dio)
	);

	initial begin
		in_clk = 1'b0;
		forever #(CLK_PERIOD / 2) in_clk = ~in_clk;
	end

	// ------------------------------
	// failure and compare
	// ------------------------------
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_byte(input string name, input bus_byte_t got, input bus_byte_t exp);
		if (got !== exp) begin
			report_failure($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_segs(input string name, input seg_t got, input seg_t exp);
		if (got !== exp) begin
			report_failure($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_part_count(input string name, input int got, input int exp);
		if (got != exp) begin
			report_failure($sformatf("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic check_line(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp));
		end
	endtask

	// ------------------------------
	// stimulus helpers
	// ------------------------------
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	function automatic digit_vec_t random_digits();
		digit_vec_t digs;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			digs[i] = digit_t'(rand_bits(4));
		end
		return digs;
	endfunction

	// gfedcba, lower case b and d
	function automatic seg_t seg_pattern(input digit_t d);
		case (d)
			4'h0: return 7'h3F;
			4'h1: return 7'h06;
			4'h2: return 7'h5B;
			4'h3: return 7'h4F;
			4'h4: return 7'h66;
			4'h5: return 7'h6D;
			4'h6: return 7'h7D;
			4'h7: return 7'h07;
			4'h8: return 7'h7F;
			4'h9: return 7'h6F;
			4'hA: return 7'h77;
			4'hB: return 7'h7C;
			4'hC: return 7'h39;
			4'hD: return 7'h5E;
			4'hE: return 7'h79;
			default: return 7'h71;
		endcase
	endfunction

	task automatic send_update(input digit_vec_t digs, input brightness_t br);
		@(posedge in_clk);
		#DRIVE_DELAY;
		in_digits     = digs;
		in_brightness = br;
		in_update     = 1'b1;
		@(posedge in_clk);
		#DRIVE_DELAY;
		in_update = 1'b0;
	endtask

	// watchdog below bounds this
	task automatic wait_stops(input int target);
		while (stop_cnt < target) @(posedge in_clk);
	endtask

	// ------------------------------
	// line decoder
	// ------------------------------
	// sampled mid-cycle, away from the register updates
	always @(negedge in_clk) begin
		if (prev_clk && out_disp_clk && prev_dio && !out_disp_dio) begin
			start_cnt++;
			bit_idx = 0;
		end else if (prev_clk && out_disp_clk && !prev_dio && out_disp_dio) begin
			// also drops the stray bit from the stop clock
			stop_cnt++;
			bit_idx = 0;
		end else if (!prev_clk && out_disp_clk) begin
			// lsb first, 9th bit is the ack clock
			if (bit_idx < 8) rx_byte = {out_disp_dio, rx_byte[7:1]};
			bit_idx++;
			if (bit_idx == 9) begin
				byte_q.push_back(rx_byte);
				part_q.push_back(start_cnt);
				bit_idx = 0;
			end
		end
		prev_clk = out_disp_clk;
		prev_dio = out_disp_dio;
	end

	always @(posedge in_clk) begin
		cycle_ctr++;
		if (cycle_ctr > TIMEOUT_CYCLES) begin
			report_failure($sformatf("timeout after %0d clock cycles", TIMEOUT_CYCLES));
		end
	end

	// ------------------------------
	// frame check
	// ------------------------------
	task automatic pop_byte(input int exp_part, output bus_byte_t got);
		check_part_count("part of byte", part_q.pop_front(), exp_part);
		got = byte_q.pop_front();
	endtask

	// digit bytes are skipped when the store changed mid-frame
	task automatic check_frame(input digit_vec_t digs, input brightness_t br, input bit with_digits);
		bus_byte_t got;
		if (byte_q.size() < NUM_DIGITS + 3) begin
			report_failure("frame ended with too few bytes on the line");
		end
		pop_byte(next_part + 1, got);
		check_byte("mode command", got, CMD_DATA_MODE);
		pop_byte(next_part + 2, got);
		check_byte("address command", got, CMD_ADDR0);
		for (int i = 0; i < NUM_DIGITS; i++) begin
			pop_byte(next_part + 2, got);
			if (got[7]) report_failure("segment byte has its top bit set");
			if (with_digits) begin
				check_segs($sformatf("segments of digit %0d", i), seg_t'(got[6:0]),
					seg_pattern(digs[i]));
			end
		end
		pop_byte(next_part + 3, got);
		check_byte("control command", got, CMD_DISP_ON | bus_byte_t'(br));
		check_part_count("stop count", stop_cnt, start_cnt);
		next_part += 3;
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic test_reset_idle();
		check_line("out_disp_clk", out_disp_clk, 1'b1);
		check_line("out_disp_dio", out_disp_dio, 1'b1);
		// update flag starts clear, so nothing goes out
		repeat (3 * WAIT_CYCLES) @(posedge in_clk);
		check_part_count("start count after reset", start_cnt, 0);
	endtask

	task automatic test_single_frame();
		digit_vec_t  digs;
		brightness_t br;
		digs = random_digits();
		br   = brightness_t'(rand_bits(3));
		send_update(digs, br);
		wait_stops(stop_cnt + 3);
		check_frame(digs, br, 1'b1);
		check_part_count("start count", start_cnt, next_part);
	endtask

	task automatic test_idle_after_frame();
		int starts_before;
		starts_before = start_cnt;
		repeat (3 * WAIT_CYCLES) @(posedge in_clk);
		check_part_count("start count while idle", start_cnt, starts_before);
		check_line("idle out_disp_dio", out_disp_dio, 1'b1);
	endtask

	// 18 positions cover all 16 patterns
	task automatic test_decode_table();
		digit_vec_t digs;
		for (int f = 0; f < 3; f++) begin
			for (int i = 0; i < NUM_DIGITS; i++) begin
				digs[i] = digit_t'((f * NUM_DIGITS + i) % 16);
			end
			send_update(digs, 3'd5);
			wait_stops(stop_cnt + 3);
			check_frame(digs, 3'd5, 1'b1);
		end
	endtask

	task automatic test_update_mid_frame();
		digit_vec_t  digs_a;
		digit_vec_t  digs_b;
		brightness_t br_a;
		brightness_t br_b;
		int          stops_before;
		digs_a = random_digits();
		br_a   = brightness_t'(rand_bits(3));
		digs_b = random_digits();
		br_b   = brightness_t'(rand_bits(3));
		stops_before = stop_cnt;
		send_update(digs_a, br_a);
		// into the segment bytes
		while (byte_q.size() < 3) @(posedge in_clk);
		send_update(digs_b, br_b);
		wait_stops(stops_before + 6);
		// control byte of the first frame already carries the new level
		check_frame(digs_a, br_b, 1'b0);
		check_frame(digs_b, br_b, 1'b1);
	endtask

	task automatic test_brightness_alone();
		digit_vec_t  digs;
		brightness_t br;
		int          starts_before;
		digs = random_digits();
		br   = ~in_brightness;
		starts_before = start_cnt;
		@(posedge in_clk);
		#DRIVE_DELAY;
		in_brightness = br;
		repeat (3 * WAIT_CYCLES) @(posedge in_clk);
		check_part_count("start count after brightness change", start_cnt, starts_before);
		send_update(digs, br);
		wait_stops(stop_cnt + 3);
		check_frame(digs, br, 1'b1);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		in_rst        = 1'b1;
		in_update     = 1'b0;
		in_digits     = '0;
		in_brightness = '0;
		lfsr_state    = 32'h0852_e6bd;
		repeat (5) @(posedge in_clk);
		#DRIVE_DELAY;
		in_rst = 1'b0;

		test_reset_idle();
		test_single_frame();
		test_idle_after_frame();
		test_decode_table();
		test_update_mid_frame();
		test_brightness_alone();

		if (byte_q.size() != 0 || start_cnt != stop_cnt) begin
			report_failure("line carried bytes or parts outside the checked frames");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tm_display_top.f
rtl/tm_disp_pkg.sv
rtl/seg_decoder.sv
rtl/wait_timer.sv
rtl/disp_sequencer.sv
rtl/tm_bus_master.sv
rtl/tm_display_top.sv
tests/tm_display_chk.sv
tests/tm_display_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the display controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tm_display_tb -f tm_display_top.f -o Vtm_display_tb

status=0
./obj_dir/Vtm_display_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
